// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_router \
    -o sim_router

./obj_dir/sim_router | tee sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
else
    exit 1
fi

// ==== src/arbiter.sv ====
`timescale 1ns/100ps

`include "router_settings.svh"

module arbiter
    import router_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  flit_u [`CHANNEL_NUMBER-1:0]  q_data_i,
    input  logic  [`CHANNEL_NUMBER-1:0]  q_last_i,
    input  logic  [`CHANNEL_NUMBER-1:0]  q_valid_i,
    output logic  [`CHANNEL_NUMBER-1:0]  q_ready_o,

    output flit_u                        arb_data_o,
    output logic                         arb_last_o,
    output logic                         arb_valid_o,
    input  logic                         arb_ready_i,

    output logic  [`COORD_X_WIDTH-1:0]   target_x_o,
    output logic  [`COORD_Y_WIDTH-1:0]   target_y_o,
    output logic                         pkt_start_o
);

    localparam int CH    = `CHANNEL_NUMBER;
    localparam int IDX_W = $clog2(CH);

    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] rr_ptr;
    logic             busy;
    logic             mid_pkt;

    logic [IDX_W-1:0] found_idx;
    logic             any_valid;
    logic [IDX_W-1:0] sel;
    logic             xfer;

    function automatic logic [IDX_W-1:0] wrap_idx(input int v);
        return IDX_W'(v % CH);
    endfunction

    // first valid queue, searching upward from the pointer
    always_comb begin
        found_idx = '0;
        any_valid = 1'b0;
        for (int k = 0; k < CH; k++) begin
            if (!any_valid && q_valid_i[wrap_idx(int'(rr_ptr) + k)]) begin
                found_idx = wrap_idx(int'(rr_ptr) + k);
                any_valid = 1'b1;
            end
        end
    end

    assign sel  = busy ? grant : found_idx;
    assign xfer = arb_valid_o & arb_ready_i;

    assign arb_data_o  = q_data_i[sel];
    assign arb_last_o  = q_last_i[sel];
    assign arb_valid_o = q_valid_i[sel];

    // ready goes back to the granted queue only
    always_comb begin
        q_ready_o      = '0;
        q_ready_o[sel] = arb_ready_i;
    end

    // header fields of the current flit
    assign pkt_start_o = ~mid_pkt;
    assign target_x_o  = arb_data_o.hdr.target_x;
    assign target_y_o  = arb_data_o.hdr.target_y;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant   <= '0;
            rr_ptr  <= '0;
            busy    <= 1'b0;
            mid_pkt <= 1'b0;
        end else begin
            if (xfer && arb_last_o) begin
                // packet done, release and move the pointer past this queue
                busy   <= 1'b0;
                rr_ptr <= wrap_idx(int'(sel) + 1);
            end else if (!busy && any_valid) begin
                // lock as soon as a header shows up, even if stalled
                busy  <= 1'b1;
                grant <= found_idx;
            end
            if (xfer) begin
                mid_pkt <= ~arb_last_o;
            end
        end
    end

endmodule

// ==== src/router.sv ====
`timescale 1ns/100ps

`include "router_settings.svh"

module router
    import router_pkg::*;
#(
    parameter int ROUTER_X = `DEFAULT_ROUTER_X,
    parameter int ROUTER_Y = `DEFAULT_ROUTER_Y
) (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  flit_u [`CHANNEL_NUMBER-1:0]  in_data_i,
    input  logic  [`CHANNEL_NUMBER-1:0]  in_last_i,
    input  logic  [`CHANNEL_NUMBER-1:0]  in_valid_i,
    output logic  [`CHANNEL_NUMBER-1:0]  in_ready_o,

    output flit_u [`CHANNEL_NUMBER-1:0]  out_data_o,
    output logic  [`CHANNEL_NUMBER-1:0]  out_last_o,
    output logic  [`CHANNEL_NUMBER-1:0]  out_valid_o,
    input  logic  [`CHANNEL_NUMBER-1:0]  out_ready_i
);

    // queue heads towards the arbiter
    flit_u [`CHANNEL_NUMBER-1:0] q_data;
    logic  [`CHANNEL_NUMBER-1:0] q_last;
    logic  [`CHANNEL_NUMBER-1:0] q_valid;
    logic  [`CHANNEL_NUMBER-1:0] q_ready;

    // single crossbar path
    flit_u                       arb_data;
    logic                        arb_last;
    logic                        arb_valid;
    logic                        arb_ready;

    logic  [`COORD_X_WIDTH-1:0]  target_x;
    logic  [`COORD_Y_WIDTH-1:0]  target_y;
    logic                        pkt_start;

    for (genvar i = 0; i < `CHANNEL_NUMBER; i++) begin : g_in_fifo
        stream_fifo #(
            .DEPTH    (`BUFFER_LENGTH)
        ) u_fifo (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .data_i   (in_data_i[i]),
            .last_i   (in_last_i[i]),
            .valid_i  (in_valid_i[i]),
            .ready_o  (in_ready_o[i]),
            .data_o   (q_data[i]),
            .last_o   (q_last[i]),
            .valid_o  (q_valid[i]),
            .ready_i  (q_ready[i])
        );
    end

    arbiter u_arbiter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .q_data_i    (q_data),
        .q_last_i    (q_last),
        .q_valid_i   (q_valid),
        .q_ready_o   (q_ready),
        .arb_data_o  (arb_data),
        .arb_last_o  (arb_last),
        .arb_valid_o (arb_valid),
        .arb_ready_i (arb_ready),
        .target_x_o  (target_x),
        .target_y_o  (target_y),
        .pkt_start_o (pkt_start)
    );

    xy_route #(
        .ROUTER_X    (ROUTER_X),
        .ROUTER_Y    (ROUTER_Y)
    ) u_xy_route (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .arb_data_i  (arb_data),
        .arb_last_i  (arb_last),
        .arb_valid_i (arb_valid),
        .arb_ready_o (arb_ready),
        .target_x_i  (target_x),
        .target_y_i  (target_y),
        .pkt_start_i (pkt_start),
        .out_data_o  (out_data_o),
        .out_last_o  (out_last_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== src/router_pkg.sv ====
`include "router_settings.svh"

package router_pkg;

    // header view of a flit, target coordinates in the top bits
    typedef struct packed {
        logic [`COORD_X_WIDTH-1:0] target_x;
        logic [`COORD_Y_WIDTH-1:0] target_y;
        logic [`DATA_WIDTH-`COORD_X_WIDTH-`COORD_Y_WIDTH-1:0] payload;
    } flit_hdr_t;

    // one word, read either as plain data or as a routing header
    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;
        flit_hdr_t              hdr;
    } flit_u;

endpackage

// ==== src/router_settings.svh ====
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// flit and channel geometry
`define DATA_WIDTH      32
`define CHANNEL_NUMBER  5
`define BUFFER_LENGTH   4

// mesh size and coordinate widths
`define MAX_ROUTERS_X   4
`define MAX_ROUTERS_Y   4
`define COORD_X_WIDTH   $clog2(`MAX_ROUTERS_X)
`define COORD_Y_WIDTH   $clog2(`MAX_ROUTERS_Y)

// default position of a router instance
`define DEFAULT_ROUTER_X 0
`define DEFAULT_ROUTER_Y 0

// channel indices
`define PORT_LOCAL      0
`define PORT_NORTH      1
`define PORT_EAST       2
`define PORT_SOUTH      3
`define PORT_WEST       4

`endif

// ==== src/stream_fifo.sv ====
`timescale 1ns/100ps

`include "router_settings.svh"

module stream_fifo
    import router_pkg::*;
#(
    parameter int DEPTH = `BUFFER_LENGTH
) (
    input  logic  clk,
    input  logic  arst_n_i,

    input  flit_u data_i,
    input  logic  last_i,
    input  logic  valid_i,
    output logic  ready_o,

    output flit_u data_o,
    output logic  last_o,
    output logic  valid_o,
    input  logic  ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // each entry holds {last, data}
    logic [`DATA_WIDTH:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign ready_o = (count != CNT_W'(DEPTH));
    assign valid_o = (count != '0);

    assign wr_en = valid_i & ready_o;
    assign rd_en = valid_o & ready_i;

    // head of queue straight from storage
    assign data_o = mem[rd_ptr][`DATA_WIDTH-1:0];
    assign last_o = mem[rd_ptr][`DATA_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {last_i, data_i};
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // a full fifo never writes, so no overflow on simultaneous access
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/xy_route.sv ====
`timescale 1ns/100ps

`include "router_settings.svh"

module xy_route
    import router_pkg::*;
#(
    parameter int ROUTER_X = `DEFAULT_ROUTER_X,
    parameter int ROUTER_Y = `DEFAULT_ROUTER_Y
) (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  flit_u                        arb_data_i,
    input  logic                         arb_last_i,
    input  logic                         arb_valid_i,
    output logic                         arb_ready_o,

    input  logic  [`COORD_X_WIDTH-1:0]   target_x_i,
    input  logic  [`COORD_Y_WIDTH-1:0]   target_y_i,
    input  logic                         pkt_start_i,

    output flit_u [`CHANNEL_NUMBER-1:0]  out_data_o,
    output logic  [`CHANNEL_NUMBER-1:0]  out_last_o,
    output logic  [`CHANNEL_NUMBER-1:0]  out_valid_o,
    input  logic  [`CHANNEL_NUMBER-1:0]  out_ready_i
);

    localparam int IDX_W = $clog2(`CHANNEL_NUMBER);

    logic [IDX_W-1:0] dec_port;
    logic [IDX_W-1:0] held_port;
    logic [IDX_W-1:0] cur_port;

    // x dimension first
    always_comb begin
        if (int'(target_x_i) > ROUTER_X) begin
            dec_port = IDX_W'(`PORT_EAST);
        end else if (int'(target_x_i) < ROUTER_X) begin
            dec_port = IDX_W'(`PORT_WEST);
        end else if (int'(target_y_i) > ROUTER_Y) begin
            dec_port = IDX_W'(`PORT_NORTH);
        end else if (int'(target_y_i) < ROUTER_Y) begin
            dec_port = IDX_W'(`PORT_SOUTH);
        end else begin
            dec_port = IDX_W'(`PORT_LOCAL);
        end
    end

    assign cur_port = pkt_start_i ? dec_port : held_port;

    // body flits follow the header's port
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            held_port <= IDX_W'(`PORT_LOCAL);
        end else if (arb_valid_i && arb_ready_o && pkt_start_i) begin
            held_port <= dec_port;
        end
    end

    always_comb begin
        out_valid_o = '0;
        for (int c = 0; c < `CHANNEL_NUMBER; c++) begin
            out_data_o[c] = arb_data_i;
            out_last_o[c] = arb_last_i;
        end
        out_valid_o[cur_port] = arb_valid_i;
    end

    assign arb_ready_o = out_ready_i[cur_port];

endmodule

// ==== tb.f ====
+incdir+src
src/router_pkg.sv
src/stream_fifo.sv
src/arbiter.sv
src/xy_route.sv
src/router.sv
verif/tb_clock_gen.sv
verif/router_checker.sv
verif/tb_router.sv

// ==== verif/router_checker.sv ====
`timescale 1ns/100ps

`include "router_settings.svh"

module router_checker (
    input logic                                          clk,
    input logic                                          arst_n_i,
    input logic [`CHANNEL_NUMBER-1:0][`DATA_WIDTH-1:0]   out_data_o,
    input logic [`CHANNEL_NUMBER-1:0]                    out_last_o,
    input logic [`CHANNEL_NUMBER-1:0]                    out_valid_o,
    input logic [`CHANNEL_NUMBER-1:0]                    out_ready_i
);

    // a stalled flit stays put until taken
    for (genvar c = 0; c < `CHANNEL_NUMBER; c++) begin : g_stall
        a_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
            out_valid_o[c] && !out_ready_i[c] |=>
                out_valid_o[c] && $stable(out_data_o[c]) && $stable(out_last_o[c]))
            else $error("output %0d changed while stalled", c);
    end

    // single crossbar path
    a_one_output: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(out_valid_o))
        else $error("more than one output valid");

    a_reset_quiet: assert property (@(posedge clk) !arst_n_i |-> out_valid_o == '0)
        else $error("output valid during reset");

endmodule

bind router router_checker u_checker (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .out_data_o  (out_data_o),
    .out_last_o  (out_last_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
);

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held for three rising edges, released away from the edge
    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// ==== verif/tb_router.sv ====
`timescale 1ns/100ps

`include "router_settings.svh"

module tb_router;

    localparam int CH = `CHANNEL_NUMBER;
    localparam int RX = 1;
    localparam int RY = 1;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                          clk;
    logic                          arst_n;
    logic [CH-1:0][`DATA_WIDTH-1:0] in_data;
    logic [CH-1:0]                 in_last;
    logic [CH-1:0]                 in_valid;
    logic [CH-1:0]                 in_ready;
    logic [CH-1:0][`DATA_WIDTH-1:0] out_data;
    logic [CH-1:0]                 out_last;
    logic [CH-1:0]                 out_valid;
    logic [CH-1:0]                 out_ready;

    // flit layout {last, tx, ty, src, seq}
    logic [32:0] src_q [CH][$];
    logic [32:0] got_q [CH][$];
    logic [32:0] exp_pq [CH*CH][$];

    logic [CH-1:0] accepted;
    int            acc_count [CH];
    int            exp_total;
    int            got_total;
    int            seq_ctr;
    int            cycles;
    int            err_count;
    int            chk_count;
    int            test_count;
    int            err_at_start;
    int            rr_model;
    int            ready_mode;
    logic [31:0]   rng_state;

    tb_clock_gen u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    router #(
        .ROUTER_X    (RX),
        .ROUTER_Y    (RY)
    ) uut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .in_data_i   (in_data),
        .in_last_i   (in_last),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_data_o  (out_data),
        .out_last_o  (out_last),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // expected output port with the x dimension first
    function automatic int xy_port(input int tx, input int ty);
        if (tx > RX) return `PORT_EAST;
        if (tx < RX) return `PORT_WEST;
        if (ty > RY) return `PORT_NORTH;
        if (ty < RY) return `PORT_SOUTH;
        return `PORT_LOCAL;
    endfunction

    // first requesting input seen from the round-robin pointer
    function automatic int first_from(input int ptr, input logic [CH-1:0] mask);
        for (int k = 0; k < CH; k++) begin
            if (mask[(ptr + k) % CH]) begin
                return (ptr + k) % CH;
            end
        end
        return -1;
    endfunction

    function automatic bit inputs_idle();
        for (int c = 0; c < CH; c++) begin
            if (src_q[c].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // inputs and output ready change on the falling edge only
    always @(negedge clk) begin
        if (arst_n) begin
            for (int c = 0; c < CH; c++) begin
                if (accepted[c]) begin
                    void'(src_q[c].pop_front());
                    accepted[c] = 1'b0;
                end
                if (src_q[c].size() != 0) begin
                    in_valid[c] = 1'b1;
                    {in_last[c], in_data[c]} = src_q[c][0];
                end else begin
                    in_valid[c] = 1'b0;
                    in_last[c]  = 1'b0;
                    in_data[c]  = '0;
                end
            end
            case (ready_mode)
                0:       out_ready = '1;
                1:       out_ready = '0;
                default: out_ready = CH'(xorshift32());
            endcase
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycles++;
            for (int c = 0; c < CH; c++) begin
                if (in_valid[c] && in_ready[c]) begin
                    accepted[c] = 1'b1;
                    acc_count[c]++;
                end
                if (out_valid[c] && out_ready[c]) begin
                    got_q[c].push_back({out_last[c], out_data[c]});
                    got_total++;
                end
            end
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: the router did not deliver all flits in %0d cycles", cycles);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    task automatic step();
        @(posedge clk);
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t %s", $time, msg);
        err_count++;
    endtask

    task automatic send_packet(input int src, input int tx, input int ty, input int len);
        logic [32:0] f;
        int          port;
        port = xy_port(tx, ty);
        for (int i = 0; i < len; i++) begin
            f = {(i == len - 1), tx[1:0], ty[1:0], src[2:0], seq_ctr[24:0]};
            seq_ctr++;
            src_q[src].push_back(f);
            exp_pq[port*CH + src].push_back(f);
            exp_total++;
        end
    endtask

    task automatic drain();
        while (!(got_total == exp_total && inputs_idle())) begin
            step();
        end
        // room for a stray duplicate to show up
        repeat (4) step();
    endtask

    // source order of the flits seen on one output
    task automatic compare_source_order(input int port, input int exp_src[$]);
        chk_count++;
        if (got_q[port].size() != exp_src.size()) begin
            report_mismatch($sformatf("output %0d got %0d flits, expected %0d",
                                      port, got_q[port].size(), exp_src.size()));
            return;
        end
        for (int i = 0; i < exp_src.size(); i++) begin
            chk_count++;
            if (int'(got_q[port][i][27:25]) != exp_src[i]) begin
                report_mismatch($sformatf("output %0d flit %0d from input %0d, expected %0d",
                                          port, i, got_q[port][i][27:25], exp_src[i]));
            end
        end
    endtask

    // every flit matched against its own source stream
    task automatic score_outputs();
        logic [32:0] f;
        logic [32:0] e;
        int          idx;
        for (int o = 0; o < CH; o++) begin
            while (got_q[o].size() != 0) begin
                f = got_q[o].pop_front();
                idx = o*CH + int'(f[27:25]);
                chk_count++;
                if (int'(f[27:25]) >= CH || exp_pq[idx].size() == 0) begin
                    report_mismatch($sformatf("unexpected flit %h on output %0d", f, o));
                end else begin
                    e = exp_pq[idx].pop_front();
                    if (f != e) begin
                        report_mismatch($sformatf("output %0d got %h, expected %h", o, f, e));
                    end
                end
            end
        end
        for (int i = 0; i < CH*CH; i++) begin
            if (exp_pq[i].size() != 0) begin
                $display("%0d flits from input %0d never reached output %0d",
                         exp_pq[i].size(), i % CH, i / CH);
                err_count++;
                exp_pq[i].delete();
            end
        end
        exp_total = 0;
        got_total = 0;
    endtask

    task automatic start_test();
        err_at_start = err_count;
        test_count++;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, err_count - err_at_start);
    endtask

    task automatic route_each_direction();
        start_test();
        send_packet(0, 2, 1, 1);
        send_packet(0, 0, 1, 1);
        send_packet(0, 1, 2, 1);
        send_packet(0, 1, 0, 1);
        send_packet(0, 1, 1, 1);
        drain();
        score_outputs();
        rr_model = 1;
        end_test("routing");
    endtask

    task automatic keep_packets_whole();
        int a;
        int b;
        int seq[$];
        start_test();
        send_packet(2, 2, 1, 4);
        send_packet(4, 3, 0, 4);
        a = first_from(rr_model, 5'b10100);
        b = (a == 2) ? 4 : 2;
        drain();
        for (int i = 0; i < 4; i++) begin
            seq.push_back(a);
        end
        for (int i = 0; i < 4; i++) begin
            seq.push_back(b);
        end
        compare_source_order(`PORT_EAST, seq);
        score_outputs();
        rr_model = (b + 1) % CH;
        end_test("packet integrity");
    endtask

    task automatic rotate_grants();
        int seq[$];
        int first;
        start_test();
        for (int c = 0; c < CH; c++) begin
            send_packet(c, 1, 1, 2);
        end
        drain();
        for (int k = 0; k < CH; k++) begin
            seq.push_back((rr_model + k) % CH);
            seq.push_back((rr_model + k) % CH);
        end
        compare_source_order(`PORT_LOCAL, seq);
        score_outputs();
        // pointer moves past input 0 after a lone packet
        send_packet(0, 1, 1, 1);
        drain();
        score_outputs();
        rr_model = 1;
        send_packet(0, 1, 1, 1);
        send_packet(1, 1, 1, 1);
        drain();
        first = first_from(rr_model, 5'b00011);
        seq.delete();
        seq.push_back(first);
        seq.push_back(1 - first);
        compare_source_order(`PORT_LOCAL, seq);
        score_outputs();
        rr_model = (1 - first + 1) % CH;
        end_test("round-robin");
    endtask

    task automatic stall_output();
        logic [32:0] held;
        start_test();
        ready_mode = 1;
        acc_count[1] = 0;
        send_packet(1, 1, 1, 8);
        held = exp_pq[`PORT_LOCAL*CH + 1][0];
        // the stalled fifo fills until it refuses the next flit
        @(negedge clk);
        while (in_ready[1] !== 1'b0) begin
            @(negedge clk);
        end
        chk_count++;
        if (acc_count[1] != `BUFFER_LENGTH) begin
            report_mismatch($sformatf("stalled input took %0d flits, expected %0d",
                                      acc_count[1], `BUFFER_LENGTH));
        end
        chk_count++;
        if (out_valid[`PORT_LOCAL] !== 1'b1 ||
            {out_last[`PORT_LOCAL], out_data[`PORT_LOCAL]} !== held) begin
            report_mismatch($sformatf("stalled output shows %b %h, expected %h",
                                      out_valid[`PORT_LOCAL],
                                      {out_last[`PORT_LOCAL], out_data[`PORT_LOCAL]}, held));
        end
        step();
        ready_mode = 0;
        drain();
        score_outputs();
        rr_model = 2;
        end_test("back-pressure");
    endtask

    task automatic mix_random_traffic();
        int src;
        int gap;
        start_test();
        ready_mode = 2;
        for (int n = 0; n < 30; n++) begin
            src = xorshift32() % CH;
            send_packet(src, xorshift32() % 4, xorshift32() % 4, 1 + xorshift32() % 4);
            gap = xorshift32() % 3;
            repeat (gap) step();
        end
        drain();
        ready_mode = 0;
        score_outputs();
        end_test("random traffic");
    endtask

    initial begin
        in_data    = '0;
        in_last    = '0;
        in_valid   = '0;
        out_ready  = '0;
        accepted   = '0;
        ready_mode = 0;
        rng_state  = 32'd58;
        exp_total  = 0;
        got_total  = 0;
        seq_ctr    = 0;
        cycles     = 0;
        err_count  = 0;
        chk_count  = 0;
        test_count = 0;
        rr_model   = 0;
        for (int c = 0; c < CH; c++) begin
            acc_count[c] = 0;
        end
        @(posedge arst_n);
        step();
        route_each_direction();
        keep_packets_whole();
        rotate_grants();
        stall_output();
        mix_random_traffic();
        $display("tests %0d, checks %0d, errors %0d", test_count, chk_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
